//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_id_stage
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log

SRCS := $(wildcard logic/*.sv verif/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/ex_operand_mux.sv
// Execute operand former
// Selects ALU operands and store data from a buffered entry
// Drops register write and memory access of illegal instructions

`timescale 1ns/1ps
`default_nettype none

module ex_operand_mux import id_pkg::*; (
  input  logic    entry_valid_i,
  output logic    entry_ready_o,
  input  id_ex_t  entry_i,

  output logic    ex_valid_o,
  input  logic    ex_ready_i,
  output ex_req_t ex_req_o
);

  // Handshake passes straight through
  assign ex_valid_o    = entry_valid_i;
  assign entry_ready_o = ex_ready_i;

  always_comb begin
    ex_req_o            = '0;
    ex_req_o.alu_op     = entry_i.alu_op;
    ex_req_o.lsu        = entry_i.lsu;
    ex_req_o.store_data = entry_i.rs2_data;
    ex_req_o.rf_we      = entry_i.rf_we;
    ex_req_o.rd         = entry_i.rd;
    ex_req_o.branch     = entry_i.branch;
    ex_req_o.jump       = entry_i.jump;
    ex_req_o.illegal    = entry_i.illegal;

    case (entry_i.op_a_sel)
      OP_A_REG_A: ex_req_o.op_a = entry_i.rs1_data;
      OP_A_PC:    ex_req_o.op_a = entry_i.pc;
      default:    ex_req_o.op_a = '0;
    endcase

    case (entry_i.op_b_sel)
      OP_B_REG_B: ex_req_o.op_b = entry_i.rs2_data;
      OP_B_IMM:   ex_req_o.op_b = entry_i.imm;
      default:    ex_req_o.op_b = XLEN'(4);  // Link offset
    endcase

    // No side effects for an illegal instruction
    if (entry_i.illegal) begin
      ex_req_o.rf_we   = 1'b0;
      ex_req_o.lsu.req = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/id_decoder.sv
// RV32I instruction decoder
// Immediate generation, register read addressing and control decode
// Purely combinational

`timescale 1ns/1ps
`default_nettype none

module id_decoder import id_pkg::*; (
  input  instr_t          instr_i,
  input  logic [XLEN-1:0] pc_i,

  output reg_addr_t       rf_raddr_a_o,
  output reg_addr_t       rf_raddr_b_o,
  input  logic [XLEN-1:0] rf_rdata_a_i,
  input  logic [XLEN-1:0] rf_rdata_b_i,

  output id_ex_t          dec_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Register file reads always follow rs1/rs2
  assign rf_raddr_a_o = instr_i[19:15];
  assign rf_raddr_b_o = instr_i[24:20];

  //////////////////////////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////////////////////////

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    dec_o          = '0;
    dec_o.pc       = pc_i;
    dec_o.rs1_data = rf_rdata_a_i;
    dec_o.rs2_data = rf_rdata_b_i;
    dec_o.rd       = instr_i[11:7];
    dec_o.alu_op   = ALU_ADD;
    dec_o.op_a_sel = OP_A_REG_A;
    dec_o.op_b_sel = OP_B_REG_B;

    case (opcode)
      OPC_OP: begin
        dec_o.rf_we = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: dec_o.alu_op = ALU_ADD;
          {7'h20, 3'b000}: dec_o.alu_op = ALU_SUB;
          {7'h00, 3'b001}: dec_o.alu_op = ALU_SLL;
          {7'h00, 3'b010}: dec_o.alu_op = ALU_SLT;
          {7'h00, 3'b011}: dec_o.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: dec_o.alu_op = ALU_XOR;
          {7'h00, 3'b101}: dec_o.alu_op = ALU_SRL;
          {7'h20, 3'b101}: dec_o.alu_op = ALU_SRA;
          {7'h00, 3'b110}: dec_o.alu_op = ALU_OR;
          {7'h00, 3'b111}: dec_o.alu_op = ALU_AND;
          default:         dec_o.illegal = 1'b1;
        endcase
      end

      OPC_OP_IMM: begin
        dec_o.rf_we    = 1'b1;
        dec_o.op_b_sel = OP_B_IMM;
        dec_o.imm      = imm_i;
        case (funct3)
          3'b000: dec_o.alu_op = ALU_ADD;
          3'b010: dec_o.alu_op = ALU_SLT;
          3'b011: dec_o.alu_op = ALU_SLTU;
          3'b100: dec_o.alu_op = ALU_XOR;
          3'b110: dec_o.alu_op = ALU_OR;
          3'b111: dec_o.alu_op = ALU_AND;
          3'b001: begin
            dec_o.alu_op  = ALU_SLL;
            dec_o.illegal = (funct7 != 7'h00);
          end
          default: begin  // SRLI / SRAI
            if (funct7 == 7'h00) begin
              dec_o.alu_op = ALU_SRL;
            end else if (funct7 == 7'h20) begin
              dec_o.alu_op = ALU_SRA;
            end else begin
              dec_o.illegal = 1'b1;
            end
          end
        endcase
      end

      OPC_LOAD: begin
        dec_o.rf_we        = 1'b1;
        dec_o.op_b_sel     = OP_B_IMM;
        dec_o.imm          = imm_i;
        dec_o.lsu.req      = 1'b1;
        dec_o.lsu.sign_ext = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: dec_o.lsu.size = LSU_BYTE;
          3'b001, 3'b101: dec_o.lsu.size = LSU_HALF;
          3'b010:         dec_o.lsu.size = LSU_WORD;
          default:        dec_o.illegal  = 1'b1;
        endcase
      end

      OPC_STORE: begin
        dec_o.op_b_sel = OP_B_IMM;
        dec_o.imm      = imm_s;
        dec_o.lsu.req  = 1'b1;
        dec_o.lsu.we   = 1'b1;
        case (funct3)
          3'b000:  dec_o.lsu.size = LSU_BYTE;
          3'b001:  dec_o.lsu.size = LSU_HALF;
          3'b010:  dec_o.lsu.size = LSU_WORD;
          default: dec_o.illegal  = 1'b1;
        endcase
      end

      OPC_BRANCH: begin
        dec_o.branch = 1'b1;
        dec_o.imm    = imm_b;  // Target is formed downstream
        case (funct3)
          3'b000:  dec_o.alu_op  = ALU_EQ;
          3'b001:  dec_o.alu_op  = ALU_NE;
          3'b100:  dec_o.alu_op  = ALU_LT;
          3'b101:  dec_o.alu_op  = ALU_GE;
          3'b110:  dec_o.alu_op  = ALU_LTU;
          3'b111:  dec_o.alu_op  = ALU_GEU;
          default: dec_o.illegal = 1'b1;
        endcase
      end

      // Jumps compute the link value pc + 4
      OPC_JAL, OPC_JALR: begin
        dec_o.jump     = 1'b1;
        dec_o.rf_we    = 1'b1;
        dec_o.op_a_sel = OP_A_PC;
        dec_o.op_b_sel = OP_B_FOUR;
        dec_o.imm      = (opcode == OPC_JAL) ? imm_j : imm_i;
        if (opcode == OPC_JALR && funct3 != 3'b000) begin
          dec_o.illegal = 1'b1;
        end
      end

      OPC_LUI, OPC_AUIPC: begin
        dec_o.rf_we    = 1'b1;
        dec_o.op_a_sel = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        dec_o.op_b_sel = OP_B_IMM;
        dec_o.imm      = imm_u;
      end

      default: dec_o.illegal = 1'b1;  // System, fence and unknown opcodes
    endcase

    // Illegal words fall back to a plain register add
    if (dec_o.illegal) begin
      dec_o.imm      = '0;
      dec_o.alu_op   = ALU_ADD;
      dec_o.op_a_sel = OP_A_REG_A;
      dec_o.op_b_sel = OP_B_REG_B;
      dec_o.branch   = 1'b0;
      dec_o.jump     = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/id_ex_buffer.sv
// Generic valid/ready circular queue
// Holds decoded instructions between decode and execute

`timescale 1ns/1ps
`default_nettype none

module id_ex_buffer #(
  parameter int unsigned DEPTH     = 2,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,

  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + PTR_W'(1);
  endfunction

  // Ready only looks at occupancy, never at the output side
  assign in_ready_o  = (count_q < CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= in_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/id_pkg.sv
// Shared definitions for the RV32I decode stage
// Widths, opcode and ALU encodings, operand selects
// LSU control, decode-to-execute entry and execute request structs

`default_nettype none

package id_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       instr_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Major opcodes kept by this stage
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // Branch compares
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic [1:0] {
    OP_B_REG_B,
    OP_B_IMM,
    OP_B_FOUR
  } op_b_sel_e;

  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_size_e;

  //////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic      req;       // Memory access requested
    logic      we;        // Store when set
    lsu_size_e size;
    logic      sign_ext;  // Loads only
  } lsu_ctrl_t;

  // One decoded instruction, held between decode and execute
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    op_a_sel_e       op_a_sel;
    op_b_sel_e       op_b_sel;
    lsu_ctrl_t       lsu;
    logic            rf_we;
    reg_addr_t       rd;
    logic            branch;
    logic            jump;
    logic            illegal;
  } id_ex_t;

  // Request handed to execute
  typedef struct packed {
    alu_op_e         alu_op;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    lsu_ctrl_t       lsu;
    logic [XLEN-1:0] store_data;
    logic            rf_we;
    reg_addr_t       rd;
    logic            branch;
    logic            jump;
    logic            illegal;
  } ex_req_t;

endpackage

`default_nettype wire

//--- logic/id_stage_top.sv
// Instruction decode stage top level
// Decoder, decode-to-execute buffer and operand former

`timescale 1ns/1ps
`default_nettype none

module id_stage_top import id_pkg::*; #(
  parameter int unsigned BUF_DEPTH = 2
) (
  input  logic            clk_i,
  input  logic            rst_ni,

  // Fetch side
  input  logic            instr_valid_i,
  output logic            instr_ready_o,
  input  instr_t          instr_i,
  input  logic [XLEN-1:0] pc_i,

  // Register file read port
  output reg_addr_t       rf_raddr_a_o,
  output reg_addr_t       rf_raddr_b_o,
  input  logic [XLEN-1:0] rf_rdata_a_i,
  input  logic [XLEN-1:0] rf_rdata_b_i,

  // Execute side
  output logic            ex_valid_o,
  input  logic            ex_ready_i,
  output ex_req_t         ex_req_o
);

  id_ex_t dec;        // Decoder result
  id_ex_t buf_entry;  // Head of buffer
  logic   buf_valid;
  logic   buf_ready;

  id_decoder u_decoder (
    .instr_i      (instr_i),
    .pc_i         (pc_i),
    .rf_raddr_a_o (rf_raddr_a_o),
    .rf_raddr_b_o (rf_raddr_b_o),
    .rf_rdata_a_i (rf_rdata_a_i),
    .rf_rdata_b_i (rf_rdata_b_i),
    .dec_o        (dec)
  );

  id_ex_buffer #(
    .DEPTH     (BUF_DEPTH),
    .payload_t (id_ex_t)
  ) u_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (instr_valid_i),
    .in_ready_o  (instr_ready_o),
    .in_data_i   (dec),
    .out_valid_o (buf_valid),
    .out_ready_i (buf_ready),
    .out_data_o  (buf_entry)
  );

  ex_operand_mux u_operand_mux (
    .entry_valid_i (buf_valid),
    .entry_ready_o (buf_ready),
    .entry_i       (buf_entry),
    .ex_valid_o    (ex_valid_o),
    .ex_ready_i    (ex_ready_i),
    .ex_req_o      (ex_req_o)
  );

endmodule

`default_nettype wire

//--- sim.f
logic/id_pkg.sv
logic/id_decoder.sv
logic/id_ex_buffer.sv
logic/ex_operand_mux.sv
logic/id_stage_top.sv
verif/id_stage_props.sv
verif/tb_id_stage.sv

//--- verif/id_stage_props.sv
// Concurrent assertions on the decode stage handshakes
// Bound into id_stage_top

`timescale 1ns/1ps
`default_nettype none

module id_stage_props import id_pkg::*; (
  input logic    clk_i,
  input logic    rst_ni,
  input logic    instr_ready_o,
  input logic    ex_valid_o,
  input logic    ex_ready_i,
  input ex_req_t ex_req_o
);

  // Nothing to hand out right after reset
  a_idle_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !ex_valid_o)
    else $error("ex_valid_o high in the first cycle after reset");

  // Stalled request must not change
  a_hold_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ex_valid_o && !ex_ready_i |=> ex_valid_o && $stable(ex_req_o))
    else $error("ex_valid_o or ex_req_o changed while stalled");

  a_full_implies_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !instr_ready_o |-> ex_valid_o)  // Full buffer always has a head
    else $error("instr_ready_o low with an empty buffer");

endmodule

bind id_stage_top id_stage_props u_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .instr_ready_o (instr_ready_o),
  .ex_valid_o    (ex_valid_o),
  .ex_ready_i    (ex_ready_i),
  .ex_req_o      (ex_req_o)
);

`default_nettype wire

//--- verif/tb_id_stage.sv
// Testbench for the RV32I decode stage
// Clock and reset, register file model, reference decode, scoreboard
// Directed opcode sweeps, random illegal words and back-pressure

`timescale 1ns/1ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

  localparam int unsigned TIMEOUT = 200;  // Cycles per wait

  logic            clk_i;
  logic            rst_ni;
  logic            instr_valid_i;
  logic            instr_ready_o;
  instr_t          instr_i;
  logic [XLEN-1:0] pc_i;
  reg_addr_t       rf_raddr_a_o;
  reg_addr_t       rf_raddr_b_o;
  logic [XLEN-1:0] rf_rdata_a_i;
  logic [XLEN-1:0] rf_rdata_b_i;
  logic            ex_valid_o;
  logic            ex_ready_i;
  ex_req_t         ex_req_o;

  integer          seed;
  int              n_checks;
  int              n_errors;
  int              n_sent;
  int              n_recv;
  logic            timed_out;
  int              ready_mode;   // 0 always ready, 1 random stalls, 2 stalled
  int unsigned     hold_cnt;
  ex_req_t         exp_q[$];
  instr_t          stim_instr[$];
  logic [XLEN-1:0] stim_pc[$];

  id_stage_top #(
    .BUF_DEPTH (2)
  ) uut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rf_raddr_a_o  (rf_raddr_a_o),
    .rf_raddr_b_o  (rf_raddr_b_o),
    .rf_rdata_a_i  (rf_rdata_a_i),
    .rf_rdata_b_i  (rf_rdata_b_i),
    .ex_valid_o    (ex_valid_o),
    .ex_ready_i    (ex_ready_i),
    .ex_req_o      (ex_req_o)
  );

  // Register N holds N in every byte, x0 is zero
  function automatic logic [XLEN-1:0] reg_value(input reg_addr_t a);
    return (a == '0) ? '0 : {4{3'b000, a}};
  endfunction

  assign rf_rdata_a_i = reg_value(rf_raddr_a_o);
  assign rf_rdata_b_i = reg_value(rf_raddr_b_o);

  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e compare_from_f3(input logic [2:0] f3);
    case (f3)
      3'd0:    return ALU_EQ;
      3'd1:    return ALU_NE;
      3'd4:    return ALU_LT;
      3'd5:    return ALU_GE;
      3'd6:    return ALU_LTU;
      default: return ALU_GEU;
    endcase
  endfunction

  function automatic lsu_size_e size_from_f3(input logic [2:0] f3);
    if (f3[1:0] == 2'd0) return LSU_BYTE;
    if (f3[1:0] == 2'd1) return LSU_HALF;
    return LSU_WORD;
  endfunction

  function automatic logic kept_opcode(input logic [6:0] opc);
    return opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH,
                       OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC};
  endfunction

  function automatic ex_req_t expected_req(input instr_t w, input logic [XLEN-1:0] pc);
    ex_req_t         r;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [XLEN-1:0] rs1v;
    logic [XLEN-1:0] rs2v;
    logic            ok;
    f3   = w[14:12];
    f7   = w[31:25];
    rs1v = reg_value(w[19:15]);
    rs2v = reg_value(w[24:20]);
    r            = '0;
    r.alu_op     = ALU_ADD;
    r.op_a       = rs1v;
    r.op_b       = rs2v;
    r.store_data = rs2v;
    r.rd         = w[11:7];
    ok           = 1'b1;
    case (w[6:0])
      OPC_OP: begin
        ok       = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        r.alu_op = alu_from_f3(f3, f7[5]);
        r.rf_we  = 1'b1;
      end
      OPC_OP_IMM: begin
        if (f3 == 3'd1) ok = (f7 == 7'h00);
        if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
        r.alu_op = alu_from_f3(f3, (f3 == 3'd5) && f7[5]);
        r.op_b   = {{20{w[31]}}, w[31:20]};
        r.rf_we  = 1'b1;
      end
      OPC_LOAD: begin
        ok             = (f3 != 3'd3) && (f3 < 3'd6);
        r.op_b         = {{20{w[31]}}, w[31:20]};
        r.rf_we        = 1'b1;
        r.lsu.req      = 1'b1;
        r.lsu.size     = size_from_f3(f3);
        r.lsu.sign_ext = ~f3[2];
      end
      OPC_STORE: begin
        ok         = (f3 < 3'd3);
        r.op_b     = {{20{w[31]}}, w[31:25], w[11:7]};
        r.lsu.req  = 1'b1;
        r.lsu.we   = 1'b1;
        r.lsu.size = size_from_f3(f3);
      end
      OPC_BRANCH: begin
        ok       = (f3 != 3'd2) && (f3 != 3'd3);
        r.alu_op = compare_from_f3(f3);
        r.branch = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        ok      = (w[6:0] == OPC_JAL) || (f3 == 3'd0);
        r.op_a  = pc;
        r.op_b  = 32'd4;  // Link value
        r.rf_we = 1'b1;
        r.jump  = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: begin
        r.op_a  = (w[6:0] == OPC_LUI) ? '0 : pc;
        r.op_b  = {w[31:12], 12'b0};
        r.rf_we = 1'b1;
      end
      default: ok = 1'b0;
    endcase
    // Illegal words only add two registers and flag, with no side effects
    if (!ok) begin
      r.alu_op  = ALU_ADD;
      r.op_a    = rs1v;
      r.op_b    = rs2v;
      r.lsu.req = 1'b0;
      r.rf_we   = 1'b0;
      r.branch  = 1'b0;
      r.jump    = 1'b0;
      r.illegal = 1'b1;
    end
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] got_v,
                                 input logic [XLEN-1:0] exp_v);
    n_errors++;
    $display("FAILED t=%0t %s got %0h expected %0h", $time, name, got_v, exp_v);
  endtask

  task automatic check_bit(input string name, input logic got_v, input logic exp_v);
    n_checks++;
    if (got_v !== exp_v) report_mismatch(name, XLEN'(got_v), XLEN'(exp_v));
  endtask

  task automatic check_lsu(input lsu_ctrl_t got_v, input lsu_ctrl_t exp_v);
    n_checks++;
    if (got_v.req !== exp_v.req)
      report_mismatch("ex_req_o.lsu.req", XLEN'(got_v.req), XLEN'(exp_v.req));
    if (got_v.we !== exp_v.we)
      report_mismatch("ex_req_o.lsu.we", XLEN'(got_v.we), XLEN'(exp_v.we));
    if (got_v.size !== exp_v.size)
      report_mismatch("ex_req_o.lsu.size", XLEN'(got_v.size), XLEN'(exp_v.size));
    if (got_v.sign_ext !== exp_v.sign_ext)
      report_mismatch("ex_req_o.lsu.sign_ext", XLEN'(got_v.sign_ext), XLEN'(exp_v.sign_ext));
  endtask

  task automatic check_req(input ex_req_t got_v, input ex_req_t exp_v);
    n_checks++;
    if (got_v.alu_op !== exp_v.alu_op)
      report_mismatch("ex_req_o.alu_op", XLEN'(got_v.alu_op), XLEN'(exp_v.alu_op));
    if (got_v.op_a !== exp_v.op_a) report_mismatch("ex_req_o.op_a", got_v.op_a, exp_v.op_a);
    if (got_v.op_b !== exp_v.op_b) report_mismatch("ex_req_o.op_b", got_v.op_b, exp_v.op_b);
    if (got_v.store_data !== exp_v.store_data)
      report_mismatch("ex_req_o.store_data", got_v.store_data, exp_v.store_data);
    if (got_v.rf_we !== exp_v.rf_we)
      report_mismatch("ex_req_o.rf_we", XLEN'(got_v.rf_we), XLEN'(exp_v.rf_we));
    if (got_v.rd !== exp_v.rd) report_mismatch("ex_req_o.rd", XLEN'(got_v.rd), XLEN'(exp_v.rd));
    if (got_v.branch !== exp_v.branch)
      report_mismatch("ex_req_o.branch", XLEN'(got_v.branch), XLEN'(exp_v.branch));
    if (got_v.jump !== exp_v.jump)
      report_mismatch("ex_req_o.jump", XLEN'(got_v.jump), XLEN'(exp_v.jump));
    if (got_v.illegal !== exp_v.illegal)
      report_mismatch("ex_req_o.illegal", XLEN'(got_v.illegal), XLEN'(exp_v.illegal));
    // Size, direction and sign of an illegal access are don't-care
    if (exp_v.illegal) begin
      check_bit("ex_req_o.lsu.req", got_v.lsu.req, exp_v.lsu.req);
    end else begin
      check_lsu(got_v.lsu, exp_v.lsu);
    end
  endtask

  // Scoreboard, output side first so a same-edge push is never popped
  always @(posedge clk_i) begin
    if (rst_ni && ex_valid_o && ex_ready_i) begin
      n_recv++;
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("Request at t=%0t arrived with nothing outstanding", $time);
      end else begin
        check_req(ex_req_o, exp_q.pop_front());
      end
    end
    if (rst_ni && instr_valid_i && instr_ready_o) begin
      n_sent++;
      exp_q.push_back(expected_req(instr_i, pc_i));
    end
  end

  // Downstream ready, mode taken at the edge
  always begin : ready_drive
    int   mode;
    logic [31:0] rnd;
    @(posedge clk_i);
    mode = ready_mode;
    #1;
    if (mode == 0) begin
      ex_ready_i = 1'b1;
    end else if (mode == 2) begin
      ex_ready_i = 1'b0;
    end else if (hold_cnt == 0) begin
      rnd        = $random(seed);
      ex_ready_i = rnd[0];
      hold_cnt   = rnd[5:3];  // Length of the stretch
    end else begin
      hold_cnt--;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic add_stim(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                          input bit set_f3, input bit set_f7);
    instr_t          w;
    logic [XLEN-1:0] p;
    w      = $random(seed);
    p      = $random(seed);
    w[6:0] = opc;
    if (set_f3) w[14:12] = f3;
    if (set_f7) w[31:25] = f7;
    stim_instr.push_back(w);
    stim_pc.push_back({p[31:2], 2'b00});
  endtask

  task automatic build_stimulus();
    logic [6:0] opc;
    for (int r = 0; r < 2; r++) begin
      for (int f = 0; f < 8; f++) begin
        add_stim(OPC_OP, 3'(f), 7'h00, 1'b1, 1'b1);
        add_stim(OPC_OP, 3'(f), 7'h20, 1'b1, 1'b1);
        add_stim(OPC_OP_IMM, 3'(f), 7'h00, 1'b1, 1'b1);
        add_stim(OPC_OP_IMM, 3'(f), 7'h20, 1'b1, 1'b1);
        add_stim(OPC_LOAD, 3'(f), 7'h00, 1'b1, 1'b0);
        add_stim(OPC_STORE, 3'(f), 7'h00, 1'b1, 1'b0);
        add_stim(OPC_BRANCH, 3'(f), 7'h00, 1'b1, 1'b0);
        add_stim(OPC_JALR, 3'(f), 7'h00, 1'b1, 1'b0);
      end
    end
    for (int i = 0; i < 4; i++) begin
      add_stim(OPC_JAL, 3'd0, 7'h00, 1'b0, 1'b0);
      add_stim(OPC_LUI, 3'd0, 7'h00, 1'b0, 1'b0);
      add_stim(OPC_AUIPC, 3'd0, 7'h00, 1'b0, 1'b0);
      add_stim(OPC_OP, 3'd0, 7'h00, 1'b0, 1'b0);      // Random funct7
      add_stim(OPC_OP_IMM, 3'd0, 7'h00, 1'b0, 1'b0);
    end
    // Random opcodes outside the kept set
    for (int i = 0; i < 12; i++) begin
      opc = 7'($random(seed));
      if (kept_opcode(opc)) opc = 7'b1110011;
      add_stim(opc, 3'd0, 7'h00, 1'b0, 1'b0);
    end
  endtask

  task automatic drive_instr(input instr_t w, input logic [XLEN-1:0] p);
    instr_valid_i = 1'b1;
    instr_i       = w;
    pc_i          = p;
  endtask

  task automatic wait_accept();
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < TIMEOUT) begin
      @(posedge clk_i);
      done = instr_ready_o;
      cycles++;
    end
    #1;
    instr_valid_i = 1'b0;
    if (!done) begin
      timed_out = 1'b1;
      n_errors++;
      $display("Timeout: instruction %h never accepted", instr_i);
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (exp_q.size() != 0) begin
      timed_out = 1'b1;
      n_errors++;
      $display("Timeout: %0d requests never left the stage", exp_q.size());
    end
  endtask

  task automatic run_list();
    for (int i = 0; i < stim_instr.size(); i++) begin
      if (!timed_out) begin
        drive_instr(stim_instr[i], stim_pc[i]);
        wait_accept();
      end
    end
  endtask

  task automatic stall_test();
    @(posedge clk_i);
    #1;
    for (int i = 0; i < 2; i++) begin
      drive_instr(stim_instr[i], stim_pc[i]);
      wait_accept();
    end
    check_bit("instr_ready_o", instr_ready_o, 1'b0);
    check_bit("ex_valid_o", ex_valid_o, 1'b1);
    drive_instr(stim_instr[2], stim_pc[2]);
    repeat (4) begin
      @(posedge clk_i);
      check_bit("instr_ready_o", instr_ready_o, 1'b0);
    end
    #1;
    ready_mode = 0;
    wait_accept();
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    ex_ready_i    = 1'b0;
    seed          = 82;
    n_checks      = 0;
    n_errors      = 0;
    n_sent        = 0;
    n_recv        = 0;
    timed_out     = 1'b0;
    ready_mode    = 0;
    hold_cnt      = 0;
    build_stimulus();

    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    check_bit("ex_valid_o", ex_valid_o, 1'b0);
    check_bit("instr_ready_o", instr_ready_o, 1'b1);
    #1;

    run_list();           // Full throughput
    wait_drain();
    ready_mode = 1;
    run_list();           // Random downstream stalls
    wait_drain();
    ready_mode = 2;
    if (!timed_out) stall_test();
    wait_drain();

    if (n_sent != n_recv) begin
      n_errors++;
      $display("Request count mismatch, %0d accepted and %0d delivered", n_sent, n_recv);
    end
    $display("Summary: %0d checks, %0d errors, %0d accepted, %0d delivered",
             n_checks, n_errors, n_sent, n_recv);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
